//--- verilog/platformer_pkg.sv
// platformer shared definitions
// screen coordinate, velocity and colour types, the pad command and
// player state structs, level geometry, palette and the fixed
// platform and coin tables
package platformer_pkg;

    //////////////////////////////
    // types
    //////////////////////////////
    typedef logic [9:0]        coord_t;
    // negative is upward
    typedef logic signed [6:0] vel_t;
    // 4 bits each of r, g, b
    typedef logic [11:0]       color_t;

    typedef enum logic {
        GROUNDED = 1'b0,
        AIRBORNE = 1'b1
    } motion_e;

    // step is the one-cycle physics tick
    typedef struct packed {
        logic left;
        logic right;
        logic jump;
        logic step;
    } pad_cmd_t;

    // x, y is the top-left corner of the box
    typedef struct packed {
        coord_t  x;
        coord_t  y;
        vel_t    v;
        motion_e mode;
    } player_t;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam coord_t CHAR_W        = 10'd32;
    localparam coord_t CHAR_H        = 10'd32;
    localparam coord_t TILE_H        = 10'd24;
    localparam coord_t COIN_SIZE     = 10'd16;
    localparam coord_t GROUND_Y      = 10'd460;
    localparam coord_t GROUND_BOTTOM = 10'd516;
    localparam coord_t SCREEN_LEFT   = 10'd143;
    localparam coord_t SCREEN_RIGHT  = 10'd734;
    localparam coord_t START_X       = 10'd300;
    // feet may sink this far below a platform top and still stand
    localparam coord_t STAND_TOL     = 10'd10;

    // jump launch speed and gravity per update
    localparam vel_t V_INIT = 7'sd15;
    localparam vel_t G      = 7'sd1;

    //////////////////////////////
    // level tables
    //////////////////////////////
    localparam int NUM_PLATFORMS = 4;
    localparam int NUM_COINS     = 4;

    localparam coord_t PLAT_X0 [NUM_PLATFORMS] = '{10'd500, 10'd250, 10'd600, 10'd378};
    localparam coord_t PLAT_X1 [NUM_PLATFORMS] = '{10'd540, 10'd280, 10'd640, 10'd450};
    localparam coord_t PLAT_Y  [NUM_PLATFORMS] = '{10'd400, 10'd500, 10'd400, 10'd350};

    localparam coord_t COIN_X [NUM_COINS] = '{10'd400, 10'd250, 10'd600, 10'd378};
    localparam coord_t COIN_Y [NUM_COINS] = '{10'd444, 10'd500, 10'd384, 10'd334};

    //////////////////////////////
    // palette
    //////////////////////////////
    localparam color_t BLACK        = 12'h000;
    localparam color_t SKY          = 12'h7AF;
    localparam color_t PLAYER_RGB   = 12'hF00;
    localparam color_t GROUND_RGB   = 12'h840;
    localparam color_t PLATFORM_RGB = 12'h0F0;
    localparam color_t COIN_RGB     = 12'hFF0;

endpackage

//--- verilog/pad_decode.sv
`timescale 1ns/1ps
// pad decode
// brings the three buttons into the clock domain through two flops
// and divides the clock down to the one-cycle physics step tick.
// left wins over right so the command never asks for both
module pad_decode import platformer_pkg::*; #(
    parameter int STEP_DIV = 500000
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     btn_left,
    input  logic     btn_right,
    input  logic     btn_jump,
    output pad_cmd_t cmd
);

    localparam int CNT_W = $clog2(STEP_DIV + 1);

    // bit 2 left, bit 1 right, bit 0 jump
    logic [2:0]       btn_meta;
    logic [2:0]       btn_sync;
    logic [CNT_W-1:0] step_cnt;
    logic             step_q;

    // two-flop synchroniser
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= {btn_left, btn_right, btn_jump};
            btn_sync <= btn_meta;
        end
    end

    // step divider, first tick STEP_DIV clocks out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            step_q   <= 1'b0;
        end else if (step_cnt == CNT_W'(STEP_DIV - 1)) begin
            step_cnt <= '0;
            step_q   <= 1'b1;
        end else begin
            step_cnt <= step_cnt + 1'b1;
            step_q   <= 1'b0;
        end
    end

    // right masked whenever left is held
    assign cmd = '{left:  btn_sync[2],
                   right: btn_sync[1] & ~btn_sync[2],
                   jump:  btn_sync[0],
                   step:  step_q};

endmodule

//--- verilog/motion_execute.sv
`timescale 1ns/1ps
// motion execute
// player FSM, one update per step tick. walks left/right with
// edge and platform blocking, launches jumps, applies gravity every
// GRAV_DIV-th tick while airborne, bumps heads on platform
// undersides and lands on the ground or a platform top
module motion_execute import platformer_pkg::*; #(
    parameter int GRAV_DIV = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  pad_cmd_t cmd,
    output player_t  player
);

    localparam int PH_W = (GRAV_DIV > 1) ? $clog2(GRAV_DIV) : 1;

    player_t         p_q;
    logic [PH_W-1:0] grav_phase;
    coord_t          nx;
    coord_t          feet;
    coord_t          y_fall;
    coord_t          sup_top;
    logic            sup_hit;
    logic            head_hit;

    //////////////////////////////
    // platform tests
    //////////////////////////////

    // either box edge strictly inside the span of platform i
    function automatic logic span_hit(input coord_t x, input int i);
        return ((x + CHAR_W > PLAT_X0[i]) && (x + CHAR_W < PLAT_X1[i])) ||
               ((x > PLAT_X0[i]) && (x < PLAT_X1[i]));
    endfunction

    // box at (x, y) would sit inside some platform
    function automatic logic blocked(input coord_t x, input coord_t y);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (span_hit(x, i) && (y + CHAR_H > PLAT_Y[i]) && (y < PLAT_Y[i] + TILE_H))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // horizontal move comes first
    always_comb begin
        nx = p_q.x;
        if (cmd.left && (p_q.x > SCREEN_LEFT) && !blocked(p_q.x - 10'd1, p_q.y))
            nx = p_q.x - 10'd1;
        else if (cmd.right && (p_q.x + CHAR_W < SCREEN_RIGHT) &&
                 !blocked(p_q.x + 10'd1, p_q.y))
            nx = p_q.x + 10'd1;
    end

    assign feet   = p_q.y + CHAR_H;
    // sign-extend v before the add
    assign y_fall = p_q.y + {{3{p_q.v[6]}}, p_q.v};

    // support and head contact, taken at the post-move x
    always_comb begin
        sup_hit  = 1'b0;
        sup_top  = GROUND_Y;
        head_hit = 1'b0;
        // ground has first claim
        if (feet >= GROUND_Y)
            sup_hit = 1'b1;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (span_hit(nx, i)) begin
                if (!sup_hit && (feet >= PLAT_Y[i]) && (feet <= PLAT_Y[i] + STAND_TOL)) begin
                    sup_hit = 1'b1;
                    sup_top = PLAT_Y[i];
                end
                if ((p_q.y <= PLAT_Y[i] + TILE_H) && (p_q.y > PLAT_Y[i]))
                    head_hit = 1'b1;
            end
        end
    end

    //////////////////////////////
    // state update
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p_q        <= '{x: START_X, y: GROUND_Y - CHAR_H, v: '0, mode: GROUNDED};
            grav_phase <= '0;
        end else if (cmd.step) begin
            p_q.x <= nx;
            case (p_q.mode)
                GROUNDED: begin
                    grav_phase <= '0;
                    if (cmd.jump) begin
                        p_q.v    <= -V_INIT;
                        p_q.mode <= AIRBORNE;
                    end else if (!sup_hit) begin
                        // walked off an edge, start a slow fall
                        p_q.v    <= 7'sd1;
                        p_q.mode <= AIRBORNE;
                    end
                end
                AIRBORNE: begin
                    if (grav_phase == PH_W'(GRAV_DIV - 1)) begin
                        grav_phase <= '0;
                        if ((p_q.v < 0) && head_hit) begin
                            // head bump, stall the rise
                            p_q.v <= '0;
                        end else if ((p_q.v > 0) && sup_hit) begin
                            // land, snap feet onto the support
                            p_q.y    <= sup_top - CHAR_H;
                            p_q.v    <= '0;
                            p_q.mode <= GROUNDED;
                        end else begin
                            p_q.y <= y_fall;
                            p_q.v <= p_q.v + G;
                        end
                    end else begin
                        grav_phase <= grav_phase + 1'b1;
                    end
                end
            endcase
        end
    end

    assign player = p_q;

endmodule

//--- verilog/coin_tracker.sv
`timescale 1ns/1ps
// coin tracker
// one sticky collected bit per coin, set once the player box
// strictly overlaps that coin's square. cleared only by reset
module coin_tracker import platformer_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  player_t              player,
    output logic [NUM_COINS-1:0] coins
);

    logic [NUM_COINS-1:0] touch;

    // box against each coin square, strict on all four sides
    always_comb begin
        for (int i = 0; i < NUM_COINS; i++) begin
            touch[i] = (player.x + CHAR_W > COIN_X[i]) &&
                       (player.x < COIN_X[i] + COIN_SIZE) &&
                       (player.y + CHAR_H > COIN_Y[i]) &&
                       (player.y < COIN_Y[i] + COIN_SIZE);
        end
    end

    // bits only ever get set
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            coins <= '0;
        else
            coins <= coins | touch;
    end

endmodule

//--- verilog/scene_render.sv
`timescale 1ns/1ps
// scene render
// two-stage pixel pipeline. stage one classifies the scan position
// against the player box, ground strip, platforms and live coins.
// stage two resolves the colour by priority into rgb
module scene_render import platformer_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  coord_t               hcount,
    input  coord_t               vcount,
    input  logic                 bright,
    input  player_t              player,
    input  logic [NUM_COINS-1:0] coins,
    output color_t               rgb
);

    // what the current pixel lands on
    typedef struct packed {
        logic bright;
        logic player_px;
        logic ground_px;
        logic plat_px;
        logic coin_px;
    } pix_hit_t;

    pix_hit_t hit_d;
    pix_hit_t hit_q;
    color_t   pix_rgb;

    //////////////////////////////
    // stage one, classify
    //////////////////////////////
    always_comb begin
        hit_d.bright    = bright;
        hit_d.player_px = (hcount >= player.x) && (hcount < player.x + CHAR_W) &&
                          (vcount >= player.y) && (vcount < player.y + CHAR_H);
        hit_d.ground_px = (vcount >= GROUND_Y) && (vcount <= GROUND_BOTTOM);
        hit_d.plat_px   = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if ((hcount >= PLAT_X0[i]) && (hcount < PLAT_X1[i]) &&
                (vcount >= PLAT_Y[i]) && (vcount < PLAT_Y[i] + TILE_H))
                hit_d.plat_px = 1'b1;
        end
        // collected coins drop out of the scene
        hit_d.coin_px = 1'b0;
        for (int i = 0; i < NUM_COINS; i++) begin
            if (!coins[i] &&
                (hcount >= COIN_X[i]) && (hcount < COIN_X[i] + COIN_SIZE) &&
                (vcount >= COIN_Y[i]) && (vcount < COIN_Y[i] + COIN_SIZE))
                hit_d.coin_px = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            hit_q <= '0;
        else
            hit_q <= hit_d;
    end

    //////////////////////////////
    // stage two, colour priority
    //////////////////////////////
    always_comb begin
        if (!hit_q.bright)
            pix_rgb = BLACK;
        else if (hit_q.player_px)
            pix_rgb = PLAYER_RGB;
        else if (hit_q.ground_px)
            pix_rgb = GROUND_RGB;
        else if (hit_q.plat_px)
            pix_rgb = PLATFORM_RGB;
        else if (hit_q.coin_px)
            pix_rgb = COIN_RGB;
        else
            pix_rgb = SKY;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rgb <= BLACK;
        else
            rgb <= pix_rgb;
    end

endmodule

//--- verilog/platformer_top.sv
`timescale 1ns/1ps
// platformer top
// pad decode feeds motion execute, whose player state drives the
// coin tracker and the pixel renderer
module platformer_top import platformer_pkg::*; #(
    parameter int STEP_DIV = 500000,
    parameter int GRAV_DIV = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_jump,
    input  logic                 bright,
    input  coord_t               hcount,
    input  coord_t               vcount,
    output color_t               rgb,
    output logic [NUM_COINS-1:0] coins
);

    pad_cmd_t cmd;
    player_t  player;

    // decode
    pad_decode #(
        .STEP_DIV (STEP_DIV)
    ) u_pad_decode (
        .clk       (clk),
        .rst       (rst),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .cmd       (cmd)
    );

    // execute
    motion_execute #(
        .GRAV_DIV (GRAV_DIV)
    ) u_motion_execute (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .player (player)
    );

    coin_tracker u_coin_tracker (
        .clk    (clk),
        .rst    (rst),
        .player (player),
        .coins  (coins)
    );

    // result, one pixel per clock
    scene_render u_scene_render (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .bright (bright),
        .player (player),
        .coins  (coins),
        .rgb    (rgb)
    );

endmodule

//--- dv/platformer_model.svh
// platformer reference model
// cycle model of the button sync, step divider, player motion, coin
// pickup and the two-deep pixel colour pipeline, stepped once per
// rising clock edge from the testbench
`ifndef PLATFORMER_MODEL_SVH
`define PLATFORMER_MODEL_SVH

logic [2:0]           m_sync1;
logic [2:0]           m_sync2;
int                   m_cnt;
logic                 m_step;
int                   m_x;
int                   m_y;
int                   m_v;
logic                 m_air;
int                   m_phase;
logic [NUM_COINS-1:0] m_coins;
// colour waiting in stage one
color_t               m_pipe;
// what rgb should show now
color_t               m_rgb;

// either side of a box at x strictly inside platform i
function automatic bit in_span(input int x, input int i);
    return (x > PLAT_X0[i] && x < PLAT_X1[i]) ||
           (x + CHAR_W > PLAT_X0[i] && x + CHAR_W < PLAT_X1[i]);
endfunction

// box at (x, y) would cut into a platform
function automatic bit side_block(input int x, input int y);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_PLATFORMS; i++) begin
        if (in_span(x, i) && y + CHAR_H > PLAT_Y[i] && y < PLAT_Y[i] + TILE_H)
            hit = 1'b1;
    end
    return hit;
endfunction

// scene priority for one pixel
function automatic color_t pixel_color(input int h, input int v, input logic b);
    if (!b)
        return BLACK;
    if (h >= m_x && h < m_x + CHAR_W && v >= m_y && v < m_y + CHAR_H)
        return PLAYER_RGB;
    if (v >= GROUND_Y && v <= GROUND_BOTTOM)
        return GROUND_RGB;
    for (int i = 0; i < NUM_PLATFORMS; i++) begin
        if (h >= PLAT_X0[i] && h < PLAT_X1[i] && v >= PLAT_Y[i] && v < PLAT_Y[i] + TILE_H)
            return PLATFORM_RGB;
    end
    for (int i = 0; i < NUM_COINS; i++) begin
        if (!m_coins[i] && h >= COIN_X[i] && h < COIN_X[i] + COIN_SIZE &&
            v >= COIN_Y[i] && v < COIN_Y[i] + COIN_SIZE)
            return COIN_RGB;
    end
    return SKY;
endfunction

task automatic model_reset();
    m_sync1 = '0;
    m_sync2 = '0;
    m_cnt   = 0;
    m_step  = 1'b0;
    m_x     = START_X;
    m_y     = GROUND_Y - CHAR_H;
    m_v     = 0;
    m_air   = 1'b0;
    m_phase = 0;
    m_coins = '0;
    m_pipe  = BLACK;
    m_rgb   = BLACK;
endtask

// one rising edge, everything read before it is written
task automatic model_clock();
    int   nx;
    int   feet;
    int   top;
    logic sup;
    logic head;
    logic l;
    logic r;
    logic j;
    m_rgb  = m_pipe;
    m_pipe = pixel_color(hcount, vcount, bright);
    // sticky pickup
    for (int i = 0; i < NUM_COINS; i++) begin
        if (m_x + CHAR_W > COIN_X[i] && m_x < COIN_X[i] + COIN_SIZE &&
            m_y + CHAR_H > COIN_Y[i] && m_y < COIN_Y[i] + COIN_SIZE)
            m_coins[i] = 1'b1;
    end
    l = m_sync2[2];
    r = m_sync2[1] & ~m_sync2[2];
    j = m_sync2[0];
    if (m_step) begin
        nx = m_x;
        if (l && m_x > SCREEN_LEFT && !side_block(m_x - 1, m_y))
            nx = m_x - 1;
        else if (r && m_x + CHAR_W < SCREEN_RIGHT && !side_block(m_x + 1, m_y))
            nx = m_x + 1;
        feet = m_y + CHAR_H;
        sup  = (feet >= GROUND_Y);
        top  = GROUND_Y;
        head = 1'b0;
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (in_span(nx, i)) begin
                if (!sup && feet >= PLAT_Y[i] && feet <= PLAT_Y[i] + STAND_TOL) begin
                    sup = 1'b1;
                    top = PLAT_Y[i];
                end
                if (m_y > PLAT_Y[i] && m_y <= PLAT_Y[i] + TILE_H)
                    head = 1'b1;
            end
        end
        m_x = nx;
        if (!m_air) begin
            m_phase = 0;
            if (j) begin
                m_v   = -V_INIT;
                m_air = 1'b1;
            end else if (!sup) begin
                m_v   = 1;
                m_air = 1'b1;
            end
        end else if (m_phase == GRAV_DIV - 1) begin
            m_phase = 0;
            if (m_v < 0 && head) begin
                m_v = 0;
            end else if (m_v > 0 && sup) begin
                m_y   = top - CHAR_H;
                m_v   = 0;
                m_air = 1'b0;
            end else begin
                m_y = m_y + m_v;
                m_v = m_v + G;
            end
        end else begin
            m_phase++;
        end
    end
    m_sync2 = m_sync1;
    m_sync1 = {btn_left, btn_right, btn_jump};
    if (m_cnt == STEP_DIV - 1) begin
        m_cnt  = 0;
        m_step = 1'b1;
    end else begin
        m_cnt++;
        m_step = 1'b0;
    end
endtask

`endif

//--- dv/platformer_tb.sv
`timescale 1ns/1ps
// platformer testbench
// drives buttons and scan position on the falling edge, steps a cycle
// model on the rising edge and checks rgb and the coin mask every cycle
module platformer_tb import platformer_pkg::*; ();

    localparam int STEP_DIV = 8;
    localparam int GRAV_DIV = 2;
    localparam int NEAR     = 0;
    localparam int ANY      = 1;
    // worst-case cycles per test
    localparam int T1_LEN   = 300;
    localparam int T2_LEN   = 6800;
    localparam int T3_LEN   = 800;
    localparam int T4_LEN   = 5000;
    localparam int T5_LEN   = 4000;
    localparam int T6_LEN   = 6000;
    localparam int CYCLE_LIMIT = 2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN);

    logic                 clk;
    logic                 rst;
    logic                 btn_left;
    logic                 btn_right;
    logic                 btn_jump;
    logic                 bright;
    coord_t               hcount;
    coord_t               vcount;
    color_t               rgb;
    logic [NUM_COINS-1:0] coins;
    integer               seed;
    int                   errors;
    int                   checks;
    int                   cycles;
    bit                   checking;

    `include "platformer_model.svh"

    platformer_top #(
        .STEP_DIV (STEP_DIV),
        .GRAV_DIV (GRAV_DIV)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .bright    (bright),
        .hcount    (hcount),
        .vcount    (vcount),
        .rgb       (rgb),
        .coins     (coins)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst)
            model_reset();
        else
            model_clock();
    end

    // every-cycle compare, outputs settled since the rising edge
    always @(negedge clk) begin
        if (checking) begin
            checks = checks + 2;
            assert (rgb === m_rgb) else begin
                $display("ERROR t=%0t rgb got %h expected %h", $time, rgb, m_rgb);
                errors++;
            end
            assert (coins === m_coins) else begin
                $display("ERROR t=%0t coins got %b expected %b", $time, coins, m_coins);
                errors++;
            end
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run went past %0d cycles without finishing", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // near the model player, or anywhere with random blanking
    task automatic pick_pixel(input int mode);
        if (mode == NEAR) begin
            hcount = coord_t'(m_x - 16 + rnd(64));
            vcount = coord_t'(m_y - 16 + rnd(64));
            bright = 1'b1;
        end else begin
            hcount = coord_t'(rnd(800));
            vcount = coord_t'(rnd(525));
            bright = (rnd(4) != 0);
        end
    endtask

    task automatic hold(input logic l, input logic r, input logic j, input int n,
                        input int mode);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            btn_left  = l;
            btn_right = r;
            btn_jump  = j;
            pick_pixel(mode);
        end
    endtask

    // walk on the model position, bounded
    task automatic walk_to(input int target);
        int n;
        n = 0;
        while (m_x != target && n < 4800) begin
            hold(m_x > target, m_x < target, 1'b0, 1, NEAR);
            n++;
        end
        hold(1'b0, 1'b0, 1'b0, 16, NEAR);
    endtask

    // one pixel through the 2-cycle pipe
    task automatic expect_pixel(input int h, input int v, input logic b, input color_t want);
        @(negedge clk);
        hcount = coord_t'(h);
        vcount = coord_t'(v);
        bright = b;
        @(negedge clk);
        @(negedge clk);
        checks++;
        assert (rgb === want) else begin
            $display("ERROR t=%0t rgb got %h expected %h at (%0d,%0d)", $time, rgb, want, h, v);
            errors++;
        end
    endtask

    function automatic bit covers(input int h, input int v);
        return h >= m_x && h < m_x + CHAR_W && v >= m_y && v < m_y + CHAR_H;
    endfunction

    // collected coin shows sky unless the player stands over it
    task automatic probe_coin(input int i);
        int h;
        int v;
        h = COIN_X[i] + COIN_SIZE / 2;
        v = COIN_Y[i] + COIN_SIZE / 2;
        if (covers(h, v))
            expect_pixel(h, v, 1'b1, PLAYER_RGB);
        else
            expect_pixel(h, v, 1'b1, SKY);
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        $display("test %0d %s done, %0d errors", num, name, errors - err0);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        int e0;
        int len;
        seed      = 32'h98f3;
        errors    = 0;
        checks    = 0;
        checking  = 1'b0;
        rst       = 1'b1;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        btn_jump  = 1'b0;
        bright    = 1'b0;
        hcount    = '0;
        vcount    = '0;
        repeat (2) @(negedge clk);
        rst      = 1'b0;
        checking = 1'b1;

        // reset state, blanking and start position
        e0 = errors;
        assert (coins === '0) else begin
            $display("ERROR t=%0t coins got %b expected 0", $time, coins);
            errors++;
        end
        expect_pixel(rnd(800), rnd(525), 1'b0, BLACK);
        expect_pixel(START_X + 5, GROUND_Y - CHAR_H + 5, 1'b1, PLAYER_RGB);
        hold(1'b0, 1'b0, 1'b0, 100, NEAR);
        hold(1'b0, 1'b0, 1'b0, 100, ANY);
        report_test(1, "reset", e0);

        // random walking, then into the left edge
        e0 = errors;
        for (int s = 0; s < 16; s++) begin
            len = 8 + rnd(160);
            if (rnd(2) == 0)
                hold(1'b1, 1'b0, 1'b0, len, NEAR);
            else
                hold(1'b0, 1'b1, 1'b0, len, NEAR);
        end
        hold(1'b1, 1'b0, 1'b0, 4000, NEAR);
        report_test(2, "walking", e0);

        // straight jump, back onto the ground
        e0 = errors;
        hold(1'b0, 1'b0, 1'b1, 24, NEAR);
        hold(1'b0, 1'b0, 1'b0, 700, NEAR);
        expect_pixel(m_x + 1, GROUND_Y - 1, 1'b1, PLAYER_RGB);
        expect_pixel(m_x + 1, GROUND_Y - CHAR_H - 1, 1'b1, SKY);
        report_test(3, "jump and land", e0);

        // head bump under platform 3
        e0 = errors;
        walk_to(400);
        hold(1'b0, 1'b0, 1'b1, 24, NEAR);
        hold(1'b0, 1'b0, 1'b0, 600, NEAR);
        // up onto platform 0, then off its right end
        walk_to(450);
        hold(1'b0, 1'b1, 1'b1, 24, NEAR);
        hold(1'b0, 1'b1, 1'b0, 1100, NEAR);
        hold(1'b0, 1'b0, 1'b0, 300, NEAR);
        report_test(4, "platforms", e0);

        // through coin 0, then up beside coin 3
        e0 = errors;
        walk_to(400);
        assert (coins[0] === 1'b1) else begin
            $display("ERROR t=%0t coins[0] got %b expected 1", $time, coins[0]);
            errors++;
        end
        walk_to(330);
        hold(1'b0, 1'b1, 1'b1, 24, NEAR);
        hold(1'b0, 1'b1, 1'b0, 240, NEAR);
        hold(1'b0, 1'b0, 1'b0, 600, NEAR);
        walk_to(300);
        for (int i = 0; i < NUM_COINS; i++) begin
            if (m_coins[i])
                probe_coin(i);
        end
        report_test(5, "coins", e0);

        // long random mix
        e0 = errors;
        for (int s = 0; s < 60; s++) begin
            len = 10 + rnd(90);
            hold(1'(rnd(2)), 1'(rnd(2)), rnd(8) == 0, len, ANY);
        end
        report_test(6, "random mix", e0);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+dv
verilog/platformer_pkg.sv
verilog/pad_decode.sv
verilog/motion_execute.sv
verilog/coin_tracker.sv
verilog/scene_render.sv
verilog/platformer_top.sv
dv/platformer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the platformer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module platformer_tb \
    -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vplatformer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
exit 1
